//--- common/tcp_glue_pkg.sv
package tcp_glue_pkg;

  // data path widths
  localparam int NET_WIDTH      = 64;                      // engine side beat
  localparam int MEM_WIDTH      = 512;                     // memory side word
  localparam int BEATS_PER_WORD = MEM_WIDTH / NET_WIDTH;   // 8 lanes per word
  localparam int NET_KEEP_W     = NET_WIDTH / 8;           // one bit per byte
  localparam int MEM_KEEP_W     = MEM_WIDTH / 8;

  // command words
  localparam int CMD_WORD_W = 72;                          // engine side
  localparam int MEM_ADDR_W = 64;                          // memory side address
  localparam int MEM_LEN_W  = 32;                          // memory side length

  // register block
  localparam int APB_ADDR_W = 4;
  localparam int CNT_W      = 16;                          // counters and fill level

  localparam logic [APB_ADDR_W-1:0] REG_RX_LIMIT = 4'h0;   // rw, buffer fill limit
  localparam logic [APB_ADDR_W-1:0] REG_RX_COUNT = 4'h4;   // ro, delayed fill level
  localparam logic [APB_ADDR_W-1:0] REG_RD_CMDS  = 4'h8;   // ro, tx read commands
  localparam logic [APB_ADDR_W-1:0] REG_RD_PKTS  = 4'hC;   // ro, tx read packets

  // engine command word, seen raw or split into fields
  typedef union packed {
    logic [CMD_WORD_W-1:0] raw;
    struct packed {
      logic [7:0]  spare_hi;                               // 71:64 unused
      logic [31:0] address;                                // 63:32
      logic [8:0]  spare_lo;                               // 31:23 unused
      logic [22:0] length;                                 // 22:0
    } fields;
  } mem_cmd_word_u;

endpackage

//--- compile.f
common/tcp_glue_pkg.sv
source/mem_cmd_slice.sv
source/tx_write_packer.sv
source/tx_read_unpacker.sv
rx_buffer/rx_buffer_fifo.sv
source/glue_regs.sv
source/tcp_mem_glue.sv
testbench/tb_tcp_mem_glue.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_tcp_mem_glue

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module "$TOP" -Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

//--- rx_buffer/rx_buffer_fifo.sv
`timescale 1ns/1ps

module rx_buffer_fifo import tcp_glue_pkg::*; #(
  parameter int DEPTH = 1024
) (
  input  logic                  net_clk,
  input  logic                  net_aresetn,
  input  logic                  in_valid,
  input  logic [NET_WIDTH-1:0]  in_data,
  input  logic [NET_KEEP_W-1:0] in_keep,
  input  logic                  in_last,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic [NET_WIDTH-1:0]  out_data,
  output logic [NET_KEEP_W-1:0] out_keep,
  output logic                  out_last,
  input  logic                  out_ready,
  input  logic [CNT_W-1:0]      rx_limit,
  output logic [CNT_W-1:0]      fill_count
);

  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int ENTRY_W = NET_WIDTH + NET_KEEP_W + 1;     // last, keep, data

  logic [ENTRY_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   fill;                                // live entry count
  logic [CNT_W-1:0]   fill_q;                              // first delay stage
  logic               push;
  logic               pop;

  // wraps at DEPTH, so depths other than powers of two work too
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready  = (fill < rx_limit) && (fill < CNT_W'(DEPTH));  // limit gate, then full
  assign push      = in_valid && in_ready;
  assign out_valid = (fill != '0);
  assign pop       = out_valid && out_ready;
  assign {out_last, out_keep, out_data} = mem[rd_ptr];    // head entry, async read

  always_ff @(posedge net_clk) begin
    if (push) begin
      mem[wr_ptr] <= {in_last, in_keep, in_data};
    end
  end

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !push) begin
        fill <= fill - 1'b1;
      end
    end
  end

  // fill level goes out through two register stages
  always_ff @(posedge net_clk) begin
    fill_q     <= fill;
    fill_count <= fill_q;
  end

  assert property (@(posedge net_clk) disable iff (!net_aresetn)
    fill <= CNT_W'(DEPTH))
    else $error("receive buffer fill count exceeds depth");

endmodule

//--- source/glue_regs.sv
`timescale 1ns/1ps

module glue_regs import tcp_glue_pkg::*; #(
  parameter int RX_BUFFER_DEPTH = 1024
) (
  input  logic                  net_clk,
  input  logic                  net_aresetn,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic [CNT_W-1:0]      fill_count,
  input  logic                  rd_cmd_fire,
  input  logic                  rd_data_fire,
  input  logic                  rd_data_last,
  output logic [CNT_W-1:0]      rx_limit
);

  logic             access;                                // apb access phase
  logic             addr_hit;                              // address maps to a register
  logic [CNT_W-1:0] rd_cmd_cnt;
  logic [CNT_W-1:0] rd_pkt_cnt;

  assign access = psel && penable;
  assign pready = 1'b1;                                    // zero wait states

  always_comb begin
    addr_hit = 1'b1;
    prdata   = '0;
    case (paddr)
      REG_RX_LIMIT: prdata = 32'(rx_limit);
      REG_RX_COUNT: prdata = 32'(fill_count);
      REG_RD_CMDS:  prdata = 32'(rd_cmd_cnt);
      REG_RD_PKTS:  prdata = 32'(rd_pkt_cnt);
      default:      addr_hit = 1'b0;                       // unaligned offsets
    endcase
  end

  // only the limit register takes writes
  assign pslverr = access && (!addr_hit || (pwrite && paddr != REG_RX_LIMIT));

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      rx_limit <= CNT_W'(RX_BUFFER_DEPTH);                 // no throttling out of reset
    end else if (access && pwrite && paddr == REG_RX_LIMIT) begin
      rx_limit <= pwdata[CNT_W-1:0];
    end
  end

  // transfer counters, both wrap
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      rd_cmd_cnt <= '0;
      rd_pkt_cnt <= '0;
    end else begin
      if (rd_cmd_fire) begin
        rd_cmd_cnt <= rd_cmd_cnt + 1'b1;
      end
      if (rd_data_fire && rd_data_last) begin
        rd_pkt_cnt <= rd_pkt_cnt + 1'b1;                   // one per packet end
      end
    end
  end

  assert property (@(posedge net_clk) disable iff (!net_aresetn)
    penable |-> psel)
    else $error("apb penable raised without psel");

endmodule

//--- source/mem_cmd_slice.sv
`timescale 1ns/1ps

module mem_cmd_slice import tcp_glue_pkg::*; (
  input  logic                  net_clk,
  input  logic                  net_aresetn,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  mem_cmd_word_u         cmd_word,
  output logic                  mem_valid,
  input  logic                  mem_ready,
  output logic [MEM_ADDR_W-1:0] mem_address,
  output logic [MEM_LEN_W-1:0]  mem_length
);

  mem_cmd_word_u held_word;                                // one-deep slot

  assign cmd_ready = !mem_valid || mem_ready;              // refill as the slot drains

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      mem_valid <= 1'b0;
    end else if (cmd_ready) begin
      mem_valid <= cmd_valid;                              // empty or taken this cycle
    end
  end

  always_ff @(posedge net_clk) begin
    if (cmd_valid && cmd_ready) begin
      held_word.raw <= cmd_word.raw;
    end
  end

  // zero extend both fields to the memory command widths
  assign mem_address = MEM_ADDR_W'(held_word.fields.address);
  assign mem_length  = MEM_LEN_W'(held_word.fields.length);

  assert property (@(posedge net_clk) disable iff (!net_aresetn)
    mem_valid && !mem_ready |=> mem_valid && $stable(held_word.raw))
    else $error("held command word changed while stalled");

endmodule

//--- source/tcp_mem_glue.sv
`timescale 1ns/1ps

module tcp_mem_glue import tcp_glue_pkg::*; #(
  parameter int RX_BUFFER_DEPTH = 1024
) (
  input  logic                  net_clk,
  input  logic                  net_aresetn,
  // engine command words
  input  logic                  rd_cmd_valid_in,
  output logic                  rd_cmd_ready_in,
  input  logic [CMD_WORD_W-1:0] rd_cmd_word_in,
  input  logic                  wr_cmd_valid_in,
  output logic                  wr_cmd_ready_in,
  input  logic [CMD_WORD_W-1:0] wr_cmd_word_in,
  // memory commands
  output logic                  m_rd_cmd_valid,
  input  logic                  m_rd_cmd_ready,
  output logic [MEM_ADDR_W-1:0] m_rd_cmd_address,
  output logic [MEM_LEN_W-1:0]  m_rd_cmd_length,
  output logic                  m_wr_cmd_valid,
  input  logic                  m_wr_cmd_ready,
  output logic [MEM_ADDR_W-1:0] m_wr_cmd_address,
  output logic [MEM_LEN_W-1:0]  m_wr_cmd_length,
  // tx write path
  input  logic                  tx_wr_data_valid,
  output logic                  tx_wr_data_ready,
  input  logic [NET_WIDTH-1:0]  tx_wr_data,
  input  logic [NET_KEEP_W-1:0] tx_wr_data_keep,
  input  logic                  tx_wr_data_last,
  output logic                  mem_wr_data_valid,
  input  logic                  mem_wr_data_ready,
  output logic [MEM_WIDTH-1:0]  mem_wr_data,
  output logic [MEM_KEEP_W-1:0] mem_wr_data_keep,
  output logic                  mem_wr_data_last,
  // tx read path
  input  logic                  mem_rd_data_valid,
  output logic                  mem_rd_data_ready,
  input  logic [MEM_WIDTH-1:0]  mem_rd_data,
  input  logic [MEM_KEEP_W-1:0] mem_rd_data_keep,
  input  logic                  mem_rd_data_last,
  output logic                  tx_rd_data_valid,
  input  logic                  tx_rd_data_ready,
  output logic [NET_WIDTH-1:0]  tx_rd_data,
  output logic [NET_KEEP_W-1:0] tx_rd_data_keep,
  output logic                  tx_rd_data_last,
  // rx buffer bypass
  input  logic                  rx_wr_data_valid,
  output logic                  rx_wr_data_ready,
  input  logic [NET_WIDTH-1:0]  rx_wr_data,
  input  logic [NET_KEEP_W-1:0] rx_wr_data_keep,
  input  logic                  rx_wr_data_last,
  output logic                  rx_rd_data_valid,
  input  logic                  rx_rd_data_ready,
  output logic [NET_WIDTH-1:0]  rx_rd_data,
  output logic [NET_KEEP_W-1:0] rx_rd_data_keep,
  output logic                  rx_rd_data_last,
  // apb
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr
);

  logic [CNT_W-1:0] rx_fill_count;                         // fifo to regs, already delayed
  logic [CNT_W-1:0] rx_limit;                              // regs to fifo gate

  mem_cmd_slice rd_cmd_slice_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn),
    .cmd_valid(rd_cmd_valid_in), .cmd_ready(rd_cmd_ready_in), .cmd_word(rd_cmd_word_in),
    .mem_valid(m_rd_cmd_valid), .mem_ready(m_rd_cmd_ready),
    .mem_address(m_rd_cmd_address), .mem_length(m_rd_cmd_length)
  );

  mem_cmd_slice wr_cmd_slice_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn),
    .cmd_valid(wr_cmd_valid_in), .cmd_ready(wr_cmd_ready_in), .cmd_word(wr_cmd_word_in),
    .mem_valid(m_wr_cmd_valid), .mem_ready(m_wr_cmd_ready),
    .mem_address(m_wr_cmd_address), .mem_length(m_wr_cmd_length)
  );

  tx_write_packer tx_write_packer_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn),
    .in_valid(tx_wr_data_valid), .in_data(tx_wr_data), .in_keep(tx_wr_data_keep),
    .in_last(tx_wr_data_last), .in_ready(tx_wr_data_ready),
    .out_valid(mem_wr_data_valid), .out_data(mem_wr_data), .out_keep(mem_wr_data_keep),
    .out_last(mem_wr_data_last), .out_ready(mem_wr_data_ready)
  );

  tx_read_unpacker tx_read_unpacker_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn),
    .in_valid(mem_rd_data_valid), .in_data(mem_rd_data), .in_keep(mem_rd_data_keep),
    .in_last(mem_rd_data_last), .in_ready(mem_rd_data_ready),
    .out_valid(tx_rd_data_valid), .out_data(tx_rd_data), .out_keep(tx_rd_data_keep),
    .out_last(tx_rd_data_last), .out_ready(tx_rd_data_ready)
  );

  rx_buffer_fifo #(
    .DEPTH(RX_BUFFER_DEPTH)
  ) rx_buffer_fifo_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn),
    .in_valid(rx_wr_data_valid), .in_data(rx_wr_data), .in_keep(rx_wr_data_keep),
    .in_last(rx_wr_data_last), .in_ready(rx_wr_data_ready),
    .out_valid(rx_rd_data_valid), .out_data(rx_rd_data), .out_keep(rx_rd_data_keep),
    .out_last(rx_rd_data_last), .out_ready(rx_rd_data_ready),
    .rx_limit(rx_limit), .fill_count(rx_fill_count)
  );

  glue_regs #(
    .RX_BUFFER_DEPTH(RX_BUFFER_DEPTH)
  ) glue_regs_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .fill_count(rx_fill_count),
    .rd_cmd_fire(m_rd_cmd_valid && m_rd_cmd_ready),        // tx read command taken
    .rd_data_fire(mem_rd_data_valid && mem_rd_data_ready),
    .rd_data_last(mem_rd_data_last),
    .rx_limit(rx_limit)
  );

endmodule

//--- source/tx_read_unpacker.sv
`timescale 1ns/1ps

module tx_read_unpacker import tcp_glue_pkg::*; (
  input  logic                  net_clk,
  input  logic                  net_aresetn,
  input  logic                  in_valid,
  input  logic [MEM_WIDTH-1:0]  in_data,
  input  logic [MEM_KEEP_W-1:0] in_keep,
  input  logic                  in_last,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic [NET_WIDTH-1:0]  out_data,
  output logic [NET_KEEP_W-1:0] out_keep,
  output logic                  out_last,
  input  logic                  out_ready
);

  localparam int LANE_W = $clog2(BEATS_PER_WORD);

  logic [MEM_WIDTH-1:0]  word_data;
  logic [MEM_KEEP_W-1:0] word_keep;
  logic                  word_last;
  logic                  word_valid;
  logic [LANE_W-1:0]     lane_idx;                         // lane on the output now
  logic [LANE_W-1:0]     last_lane;                        // highest lane with bytes
  logic                  in_fire;
  logic                  out_fire;

  // highest keep group that holds any byte
  function automatic logic [LANE_W-1:0] top_lane(input logic [MEM_KEEP_W-1:0] keep);
    logic [LANE_W-1:0] lane;
    lane = '0;
    for (int i = 0; i < BEATS_PER_WORD; i++) begin
      if (|keep[i*NET_KEEP_W +: NET_KEEP_W]) begin
        lane = LANE_W'(i);
      end
    end
    return lane;
  endfunction

  assign in_ready  = !word_valid;
  assign in_fire   = in_valid && in_ready;
  assign out_valid = word_valid;
  assign out_fire  = out_valid && out_ready;
  assign out_data  = word_data[lane_idx*NET_WIDTH +: NET_WIDTH];
  assign out_keep  = word_keep[lane_idx*NET_KEEP_W +: NET_KEEP_W];
  assign out_last  = word_last && (lane_idx == last_lane);  // only on the final beat

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      word_valid <= 1'b0;
      lane_idx   <= '0;
    end else if (in_fire) begin
      word_valid <= |in_keep;                              // a word without bytes is dropped
      lane_idx   <= '0;
    end else if (out_fire) begin
      if (lane_idx == last_lane) begin
        word_valid <= 1'b0;
        lane_idx   <= '0;
      end else begin
        lane_idx <= lane_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge net_clk) begin
    if (in_fire) begin
      word_data <= in_data;
      word_keep <= in_keep;
      word_last <= in_last;
      last_lane <= top_lane(in_keep);
    end
  end

  // memory returns bytes packed from the low end, so no gaps below the top lane
  assert property (@(posedge net_clk) disable iff (!net_aresetn)
    out_valid |-> |out_keep)
    else $error("unpacker emitted a beat without bytes");

endmodule

//--- source/tx_write_packer.sv
`timescale 1ns/1ps

module tx_write_packer import tcp_glue_pkg::*; (
  input  logic                  net_clk,
  input  logic                  net_aresetn,
  input  logic                  in_valid,
  input  logic [NET_WIDTH-1:0]  in_data,
  input  logic [NET_KEEP_W-1:0] in_keep,
  input  logic                  in_last,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic [MEM_WIDTH-1:0]  out_data,
  output logic [MEM_KEEP_W-1:0] out_keep,
  output logic                  out_last,
  input  logic                  out_ready
);

  localparam int CNT_BITS = $clog2(BEATS_PER_WORD) + 1;    // spare bit so overrun is visible

  logic [CNT_BITS-1:0] lane_cnt;                           // next lane to fill
  logic                in_fire;
  logic                close_word;

  assign in_ready   = !out_valid;                          // stall while a word waits
  assign in_fire    = in_valid && in_ready;
  assign close_word = in_fire && (in_last || lane_cnt == CNT_BITS'(BEATS_PER_WORD - 1));

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      lane_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      if (close_word) begin
        lane_cnt  <= '0;                                   // next word starts at lane 0
        out_valid <= 1'b1;
      end else begin
        if (in_fire) begin
          lane_cnt <= lane_cnt + 1'b1;
        end
        if (out_valid && out_ready) begin
          out_valid <= 1'b0;
        end
      end
    end
  end

  // the output registers double as the accumulator
  always_ff @(posedge net_clk) begin
    if (in_fire) begin
      if (lane_cnt == '0) begin
        out_keep <= '0;                                    // unfilled lanes end up with no bytes
      end
      out_data[lane_cnt*NET_WIDTH +: NET_WIDTH]   <= in_data;
      out_keep[lane_cnt*NET_KEEP_W +: NET_KEEP_W] <= in_keep;
      out_last                                    <= in_last;  // closing beat decides
    end
  end

  assert property (@(posedge net_clk) disable iff (!net_aresetn)
    lane_cnt < CNT_BITS'(BEATS_PER_WORD))
    else $error("packer lane counter ran past the last lane");

endmodule

//--- testbench/tb_tcp_mem_glue.sv
`timescale 1ns/1ps

module tb_tcp_mem_glue import tcp_glue_pkg::*; ();

  localparam int TIMEOUT  = 200;                           // cycles allowed per wait
  localparam int N_CMDS   = 8;
  localparam int N_RX     = 6;
  localparam int S_CMD_IN = 0;                             // handshake selectors
  localparam int S_PK_IN  = 1;
  localparam int S_UP_IN  = 2;
  localparam int S_RX_IN  = 3;
  localparam int S_RX_OUT = 4;
  localparam int S_APB    = 5;

  logic          net_clk, net_aresetn;
  logic          rd_cmd_valid_in, rd_cmd_ready_in, wr_cmd_valid_in, wr_cmd_ready_in;
  logic [71:0]   rd_cmd_word_in, wr_cmd_word_in;
  logic          m_rd_cmd_valid, m_rd_cmd_ready, m_wr_cmd_valid, m_wr_cmd_ready;
  logic [63:0]   m_rd_cmd_address, m_wr_cmd_address;
  logic [31:0]   m_rd_cmd_length, m_wr_cmd_length;
  logic          tx_wr_data_valid, tx_wr_data_ready, tx_wr_data_last;
  logic [63:0]   tx_wr_data;
  logic [7:0]    tx_wr_data_keep;
  logic          mem_wr_data_valid, mem_wr_data_ready, mem_wr_data_last;
  logic [511:0]  mem_wr_data;
  logic [63:0]   mem_wr_data_keep;
  logic          mem_rd_data_valid, mem_rd_data_ready, mem_rd_data_last;
  logic [511:0]  mem_rd_data;
  logic [63:0]   mem_rd_data_keep;
  logic          tx_rd_data_valid, tx_rd_data_ready, tx_rd_data_last;
  logic [63:0]   tx_rd_data;
  logic [7:0]    tx_rd_data_keep;
  logic          rx_wr_data_valid, rx_wr_data_ready, rx_wr_data_last;
  logic [63:0]   rx_wr_data;
  logic [7:0]    rx_wr_data_keep;
  logic          rx_rd_data_valid, rx_rd_data_ready, rx_rd_data_last;
  logic [63:0]   rx_rd_data;
  logic [7:0]    rx_rd_data_keep;
  logic [3:0]    paddr;
  logic          psel, penable, pwrite, pready, pslverr;
  logic [31:0]   pwdata, prdata;

  // stimulus tables that the expected values follow from
  logic [71:0]   cmd_tab [N_CMDS];
  logic [63:0]   pk_data [8];
  int            up_lanes [3] = '{5, 3, 2};                // lanes with bytes per word
  logic          up_last [3]  = '{1'b1, 1'b0, 1'b1};
  logic [63:0]   up_data [3][8];
  logic [63:0]   rx_data [N_RX];
  logic [7:0]    rx_keep [N_RX] = '{8'hff, 8'hff, 8'h0f, 8'hff, 8'hff, 8'h03};
  logic          rx_last [N_RX] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};

  int            errors, checks, tests, errs_at_start;
  int            i, accepted, pkts;
  int unsigned   seed;
  logic [71:0]   wr_word;

  tcp_mem_glue #(.RX_BUFFER_DEPTH(1024)) tcp_mem_glue_inst (.*);

  initial begin
    net_clk = 1'b0;
    forever #20 net_clk = ~net_clk;                        // 40 ns period
  end

  task automatic tick();
    @(posedge net_clk);
    #2;                                                    // drive point after the edge
  endtask

  task automatic check(input string name, input logic [511:0] got, input logic [511:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %s expected %0h actual %0h", name, exp, got);
      errors++;
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  function automatic logic handshake_ready(input int sel);
    case (sel)
      S_CMD_IN: return rd_cmd_ready_in && wr_cmd_ready_in;
      S_PK_IN:  return tx_wr_data_ready;
      S_UP_IN:  return mem_rd_data_ready;
      S_RX_IN:  return rx_wr_data_ready;
      S_RX_OUT: return rx_rd_data_valid;
      S_APB:    return pready;
      default:  return 1'b0;
    endcase
  endfunction

  // returns 1 ns after the drive point of the cycle where the handshake holds
  task automatic wait_for(input int sel, input string what);
    int t;
    t = 0;
    #1;
    while (!handshake_ready(sel)) begin
      if (t == TIMEOUT) fail_timeout(what);
      t++;
      tick();
      #1;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s finished, %0d errors", tests, name, errors - errs_at_start);
    errs_at_start = errors;
  endtask

  task automatic apb_access(input logic [3:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    tick();
    psel    = 1'b1;                                        // setup phase
    penable = 1'b0;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    tick();
    penable = 1'b1;                                        // access phase
    wait_for(S_APB, "pready");
    rdata = prdata;
    err   = pslverr;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b1, data, rdata, err);
    check("pslverr", err, exp_err);
  endtask

  task automatic apb_read(input logic [3:0] addr, input logic [31:0] exp, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b0, '0, rdata, err);
    check("pslverr", err, exp_err);
    if (!exp_err) check("prdata", rdata, exp);
  endtask

  task automatic pack_word(input int n_beats, input logic close_last);
    logic [511:0] exp_data;
    logic [511:0] exp_mask;
    logic [63:0]  exp_keep;
    int           b;
    exp_data = '0;
    exp_mask = '0;
    exp_keep = '0;
    mem_wr_data_ready = 1'b0;                              // hold the word for inspection
    for (b = 0; b < n_beats; b++) begin
      tick();
      tx_wr_data_valid = 1'b1;
      tx_wr_data       = pk_data[b];
      tx_wr_data_keep  = 8'hff;
      tx_wr_data_last  = close_last && (b == n_beats - 1);
      exp_data[b*64 +: 64] = pk_data[b];                   // beat b lands in lane b
      exp_mask[b*64 +: 64] = '1;
      exp_keep[b*8 +: 8]   = 8'hff;
      wait_for(S_PK_IN, "tx_wr_data_ready");
    end
    tick();                                                // closing transfer done
    tx_wr_data_valid = 1'b0;
    #1;
    check("mem_wr_data_valid", mem_wr_data_valid, 1);
    check("mem_wr_data", mem_wr_data & exp_mask, exp_data);  // unfilled lanes are stale
    check("mem_wr_data_keep", mem_wr_data_keep, exp_keep);
    check("mem_wr_data_last", mem_wr_data_last, close_last);
    check("tx_wr_data_ready", tx_wr_data_ready, 0);        // blocked while word waits
    tick();
    mem_wr_data_ready = 1'b1;
    tick();
    mem_wr_data_ready = 1'b0;
  endtask

  task automatic unpack_word(input int e);
    logic [511:0] word;
    logic [63:0]  keep;
    int           b;
    int           t;
    word = '0;
    keep = '0;
    for (b = 0; b < up_lanes[e]; b++) begin
      word[b*64 +: 64] = up_data[e][b];
      keep[b*8 +: 8]   = 8'hff;
    end
    tick();
    mem_rd_data_valid = 1'b1;
    mem_rd_data       = word;
    mem_rd_data_keep  = keep;
    mem_rd_data_last  = up_last[e];
    wait_for(S_UP_IN, "mem_rd_data_ready");
    tick();
    mem_rd_data_valid = 1'b0;
    b = 0;
    t = 0;
    while (b < up_lanes[e]) begin
      if (t == TIMEOUT) fail_timeout("tx_rd_data beats");
      tx_rd_data_ready = ($urandom % 2) == 1;              // random back-pressure
      #1;
      if (t == 0) check("tx_rd_data_valid", tx_rd_data_valid, 1);
      if (tx_rd_data_valid && tx_rd_data_ready) begin
        check("tx_rd_data", tx_rd_data, up_data[e][b]);
        check("tx_rd_data_keep", tx_rd_data_keep, 8'hff);
        check("tx_rd_data_last", tx_rd_data_last, up_last[e] && b == up_lanes[e] - 1);
        b++;
      end
      t++;
      tick();
    end
    tx_rd_data_ready = 1'b0;
    #1;
    check("tx_rd_data_valid", tx_rd_data_valid, 0);        // whole word emitted
  endtask

  task automatic rx_drive(input int n);
    rx_wr_data_valid = 1'b1;
    rx_wr_data       = rx_data[n];
    rx_wr_data_keep  = rx_keep[n];
    rx_wr_data_last  = rx_last[n];
  endtask

  task automatic rx_drain(input int n);
    int b;
    for (b = 0; b < n; b++) begin
      rx_rd_data_ready = 1'b1;
      wait_for(S_RX_OUT, "rx_rd_data_valid");
      check("rx_rd_data", rx_rd_data, rx_data[b]);         // order preserved
      check("rx_rd_data_keep", rx_rd_data_keep, rx_keep[b]);
      check("rx_rd_data_last", rx_rd_data_last, rx_last[b]);
      tick();
    end
    rx_rd_data_ready = 1'b0;
  endtask

  initial begin
    seed = $urandom(32'h1147);
    errors = 0;
    checks = 0;
    tests = 0;
    errs_at_start = 0;
    net_aresetn = 1'b0;
    rd_cmd_valid_in = 1'b0;
    rd_cmd_word_in = '0;
    wr_cmd_valid_in = 1'b0;
    wr_cmd_word_in = '0;
    m_rd_cmd_ready = 1'b1;                                 // memory always takes commands
    m_wr_cmd_ready = 1'b1;
    tx_wr_data_valid = 1'b0;
    tx_wr_data = '0;
    tx_wr_data_keep = '0;
    tx_wr_data_last = 1'b0;
    mem_wr_data_ready = 1'b0;
    mem_rd_data_valid = 1'b0;
    mem_rd_data = '0;
    mem_rd_data_keep = '0;
    mem_rd_data_last = 1'b0;
    tx_rd_data_ready = 1'b0;
    rx_wr_data_valid = 1'b0;
    rx_wr_data = '0;
    rx_wr_data_keep = '0;
    rx_wr_data_last = 1'b0;
    rx_rd_data_ready = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    for (i = 0; i < N_CMDS; i++) cmd_tab[i] = {8'($urandom), $urandom, $urandom};
    for (i = 0; i < 8; i++) pk_data[i] = {$urandom, $urandom};
    for (i = 0; i < 24; i++) up_data[i / 8][i % 8] = {$urandom, $urandom};
    for (i = 0; i < N_RX; i++) rx_data[i] = {$urandom, $urandom};
    pkts = 0;
    for (i = 0; i < 3; i++) pkts += up_last[i] ? 1 : 0;    // packets end on last

    repeat (16) @(posedge net_clk);
    #2 net_aresetn = 1'b1;
    #1;
    check("m_rd_cmd_valid", m_rd_cmd_valid, 0);
    check("m_wr_cmd_valid", m_wr_cmd_valid, 0);
    check("mem_wr_data_valid", mem_wr_data_valid, 0);
    check("tx_rd_data_valid", tx_rd_data_valid, 0);
    check("rx_rd_data_valid", rx_rd_data_valid, 0);
    check("pslverr", pslverr, 0);
    apb_read(REG_RX_LIMIT, 1024, 0);                       // reset limit is the depth
    apb_read(REG_RD_CMDS, 0, 0);
    apb_read(REG_RD_PKTS, 0, 0);
    end_test("reset_state");

    for (i = 0; i < N_CMDS; i++) begin
      tick();
      rd_cmd_valid_in = 1'b1;
      rd_cmd_word_in  = cmd_tab[i];
      wr_cmd_valid_in = 1'b1;
      wr_cmd_word_in  = ~cmd_tab[i];
      wait_for(S_CMD_IN, "rd_cmd_ready_in and wr_cmd_ready_in");
      check("m_rd_cmd_valid", m_rd_cmd_valid, 0);          // earlier command already gone
      tick();
      rd_cmd_valid_in = 1'b0;
      wr_cmd_valid_in = 1'b0;
      wr_word = ~cmd_tab[i];
      #1;
      check("m_rd_cmd_valid", m_rd_cmd_valid, 1);          // one cycle after the transfer
      check("m_rd_cmd_address", m_rd_cmd_address, {32'h0, cmd_tab[i][63:32]});
      check("m_rd_cmd_length", m_rd_cmd_length, {9'h0, cmd_tab[i][22:0]});
      check("m_wr_cmd_valid", m_wr_cmd_valid, 1);
      check("m_wr_cmd_address", m_wr_cmd_address, {32'h0, wr_word[63:32]});
      check("m_wr_cmd_length", m_wr_cmd_length, {9'h0, wr_word[22:0]});
    end
    end_test("cmd_format");

    pack_word(8, 1'b0);                                    // full word closes on beat 8
    pack_word(3, 1'b1);                                    // short packet closes on last
    end_test("tx_write_packer");

    for (i = 0; i < 3; i++) unpack_word(i);
    end_test("tx_read_unpacker");

    for (i = 0; i < N_RX; i++) begin
      tick();
      rx_drive(i);
      wait_for(S_RX_IN, "rx_wr_data_ready");
    end
    tick();
    rx_wr_data_valid = 1'b0;
    rx_drain(N_RX);
    apb_write(REG_RX_LIMIT, 4, 0);
    accepted = 0;
    for (i = 0; i < N_RX; i++) begin
      tick();
      rx_drive(i);
      #1;
      if (!rx_wr_data_ready) break;                        // gate closed at the limit
      accepted++;
    end
    tick();
    rx_wr_data_valid = 1'b0;
    #1;
    check("accepted beats", accepted, 4);
    check("rx_wr_data_ready", rx_wr_data_ready, 0);
    apb_read(REG_RX_COUNT, 4, 0);
    rx_drain(4);
    end_test("rx_buffer");

    apb_read(REG_RD_CMDS, N_CMDS, 0);
    apb_read(REG_RD_PKTS, pkts, 0);
    apb_write(REG_RX_LIMIT, 32'h155, 0);
    apb_read(REG_RX_LIMIT, 32'h155, 0);
    apb_read(4'h2, 0, 1);                                  // unaligned offset is unmapped
    apb_write(REG_RD_CMDS, 32'h1, 1);                      // counters are read only
    apb_read(REG_RD_CMDS, N_CMDS, 0);
    end_test("registers");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
